// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_tpu
FILELIST   ?= vlog.f
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/cfg_regs.sv ====
`default_nettype none

module cfg_regs import tpu_pkg::*; (
    input  logic                     PCLK,
    input  logic                     PRESETn,
    input  logic [REG_ADDRWIDTH-1:0] PADDR,
    input  logic                     PWRITE,
    input  logic                     PSEL,
    input  logic                     PENABLE,
    input  logic [REG_DATAWIDTH-1:0] PWDATA,
    output logic [REG_DATAWIDTH-1:0] PRDATA,
    output logic                     PREADY,
    tpu_cfg_if.cfg                   cfg,
    mem_port_if.requester            mem
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_W_ACCESS,
        ST_R_ACCESS
    } apb_state_t;

    apb_state_t               state;
    logic                     enable_pool;
    logic [MAX_BITS_POOL-1:0] kernel_size;
    // catches writes to unmapped addresses
    logic [REG_DATAWIDTH-1:0] reg_dummy;
    logic                     in_window;
    logic                     win_rd;
    logic                     win_wr;

    assign in_window = (PADDR & MEM_WINDOW_MASK) == MEM_WINDOW_BASE;

    // window read goes out in the setup cycle so data is back for the access cycle
    assign win_rd = (state == ST_IDLE) && PSEL && !PENABLE && !PWRITE && in_window;
    assign win_wr = (state == ST_W_ACCESS) && PSEL && PENABLE && in_window;

    assign mem.en    = win_rd || win_wr;
    assign mem.we    = win_wr;
    assign mem.addr  = PADDR[AWIDTH+1:2];
    assign mem.wdata = PWDATA[DWIDTH-1:0];

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state                    <= ST_IDLE;
            PRDATA                   <= '0;
            PREADY                   <= 1'b0;
            cfg.start                <= 1'b0;
            cfg.enable_matmul        <= 1'b0;
            cfg.enable_norm          <= 1'b0;
            cfg.enable_activation    <= 1'b0;
            cfg.activation_type      <= ACT_RELU;
            cfg.mean                 <= '0;
            cfg.inv_var              <= '0;
            cfg.address_mat_a        <= '0;
            cfg.address_mat_b        <= '0;
            cfg.address_mat_c        <= '0;
            cfg.address_stride_a     <= ADDR_STRIDE_WIDTH'(MAT_MUL_SIZE);
            cfg.address_stride_b     <= ADDR_STRIDE_WIDTH'(MAT_MUL_SIZE);
            cfg.address_stride_c     <= ADDR_STRIDE_WIDTH'(MAT_MUL_SIZE);
            cfg.validity_mask        <= '1;
            cfg.save_output_to_accum <= 1'b0;
            cfg.add_accum_to_output  <= 1'b0;
            enable_pool              <= 1'b0;
            kernel_size              <= MAX_BITS_POOL'(1);
            reg_dummy                <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    PRDATA <= '0;
                    PREADY <= 1'b0;
                    // only a setup cycle starts a transfer
                    if (PSEL && !PENABLE) begin
                        state <= PWRITE ? ST_W_ACCESS : ST_R_ACCESS;
                    end
                end
                ST_W_ACCESS: begin
                    if (PSEL && PENABLE) begin
                        PREADY <= 1'b1;
                        if (!in_window) begin
                            case (PADDR)
                                REG_ENABLES_ADDR: begin
                                    cfg.enable_activation <= PWDATA[3];
                                    enable_pool           <= PWDATA[2];
                                    cfg.enable_norm       <= PWDATA[1];
                                    cfg.enable_matmul     <= PWDATA[0];
                                end
                                REG_STDN_TPU_ADDR:   cfg.start <= PWDATA[0];
                                REG_MEAN_ADDR:       cfg.mean <= PWDATA[DWIDTH-1:0];
                                REG_INV_VAR_ADDR:    cfg.inv_var <= PWDATA[DWIDTH-1:0];
                                REG_MATRIX_A_ADDR:   cfg.address_mat_a <= PWDATA[AWIDTH-1:0];
                                REG_MATRIX_B_ADDR:   cfg.address_mat_b <= PWDATA[AWIDTH-1:0];
                                REG_MATRIX_C_ADDR:   cfg.address_mat_c <= PWDATA[AWIDTH-1:0];
                                REG_VALID_MASK_ADDR: cfg.validity_mask <= PWDATA[MASK_WIDTH-1:0];
                                REG_POOL_KERNEL_SIZE: kernel_size <= PWDATA[MAX_BITS_POOL-1:0];
                                REG_ACCUM_ACTIONS_ADDR: begin
                                    cfg.add_accum_to_output  <= PWDATA[1];
                                    cfg.save_output_to_accum <= PWDATA[0];
                                end
                                REG_MATRIX_A_STRIDE_ADDR:
                                    cfg.address_stride_a <= PWDATA[ADDR_STRIDE_WIDTH-1:0];
                                REG_MATRIX_B_STRIDE_ADDR:
                                    cfg.address_stride_b <= PWDATA[ADDR_STRIDE_WIDTH-1:0];
                                REG_MATRIX_C_STRIDE_ADDR:
                                    cfg.address_stride_c <= PWDATA[ADDR_STRIDE_WIDTH-1:0];
                                REG_ACTIVATION_CSR_ADDR: cfg.activation_type <= PWDATA[0];
                                default: reg_dummy <= PWDATA;
                            endcase
                        end
                    end
                    state <= ST_IDLE;
                end
                ST_R_ACCESS: begin
                    if (PSEL && PENABLE) begin
                        PREADY <= 1'b1;
                        if (in_window) begin
                            // memory words come back sign-extended
                            PRDATA <= {{(REG_DATAWIDTH-DWIDTH){mem.rdata[DWIDTH-1]}}, mem.rdata};
                        end else begin
                            case (PADDR)
                                REG_ENABLES_ADDR: PRDATA <= REG_DATAWIDTH'({cfg.enable_activation,
                                    enable_pool, cfg.enable_norm, cfg.enable_matmul});
                                REG_STDN_TPU_ADDR: PRDATA <= {cfg.done, 30'b0, cfg.start};
                                REG_MEAN_ADDR:       PRDATA <= REG_DATAWIDTH'(cfg.mean);
                                REG_INV_VAR_ADDR:    PRDATA <= REG_DATAWIDTH'(cfg.inv_var);
                                REG_MATRIX_A_ADDR:   PRDATA <= REG_DATAWIDTH'(cfg.address_mat_a);
                                REG_MATRIX_B_ADDR:   PRDATA <= REG_DATAWIDTH'(cfg.address_mat_b);
                                REG_MATRIX_C_ADDR:   PRDATA <= REG_DATAWIDTH'(cfg.address_mat_c);
                                REG_VALID_MASK_ADDR: PRDATA <= REG_DATAWIDTH'(cfg.validity_mask);
                                REG_POOL_KERNEL_SIZE: PRDATA <= REG_DATAWIDTH'(kernel_size);
                                REG_ACCUM_ACTIONS_ADDR: PRDATA <= REG_DATAWIDTH'(
                                    {cfg.add_accum_to_output, cfg.save_output_to_accum});
                                REG_MATRIX_A_STRIDE_ADDR:
                                    PRDATA <= REG_DATAWIDTH'(cfg.address_stride_a);
                                REG_MATRIX_B_STRIDE_ADDR:
                                    PRDATA <= REG_DATAWIDTH'(cfg.address_stride_b);
                                REG_MATRIX_C_STRIDE_ADDR:
                                    PRDATA <= REG_DATAWIDTH'(cfg.address_stride_c);
                                REG_ACTIVATION_CSR_ADDR:
                                    PRDATA <= REG_DATAWIDTH'(cfg.activation_type);
                                default: PRDATA <= reg_dummy;
                            endcase
                        end
                    end
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`default_nettype none

interface mem_port_if import tpu_pkg::*; #(
    parameter int AWIDTH = tpu_pkg::AWIDTH,
    parameter int DWIDTH = tpu_pkg::DWIDTH
);
    // one request per cycle with en high, read data valid the cycle after
    logic              en;
    logic              we;
    logic [AWIDTH-1:0] addr;
    logic [DWIDTH-1:0] wdata;
    logic [DWIDTH-1:0] rdata;

    modport requester (
        output en, we, addr, wdata,
        input  rdata
    );

    modport memory (
        input  en, we, addr, wdata,
        output rdata
    );
endinterface

`default_nettype wire

// ==== logic/scratch_mem.sv ====
`default_nettype none

module scratch_mem import tpu_pkg::*; #(
    parameter int AWIDTH = tpu_pkg::AWIDTH
) (
    input logic        PCLK,
    mem_port_if.memory host,
    mem_port_if.memory eng
);

    localparam int DEPTH = 2 ** AWIDTH;

    logic [DWIDTH-1:0] ram [DEPTH];

    // port b comes last so the engine wins a same-word collision
    always_ff @(posedge PCLK) begin
        if (host.en && host.we) begin
            ram[host.addr] <= host.wdata;
        end
        if (eng.en && eng.we) begin
            ram[eng.addr] <= eng.wdata;
        end
    end

    // registered read data, held between reads
    always_ff @(posedge PCLK) begin
        if (host.en && !host.we) begin
            host.rdata <= ram[host.addr];
        end
    end

    always_ff @(posedge PCLK) begin
        if (eng.en && !eng.we) begin
            eng.rdata <= ram[eng.addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/tpu_cfg_if.sv ====
`default_nettype none

interface tpu_cfg_if import tpu_pkg::*; #(
    parameter int AWIDTH = tpu_pkg::AWIDTH,
    parameter int DWIDTH = tpu_pkg::DWIDTH
);
    logic                         start;
    logic                         done;
    logic                         enable_matmul;
    logic                         enable_norm;
    logic                         enable_activation;
    logic                         activation_type;
    logic [DWIDTH-1:0]            mean;
    logic [DWIDTH-1:0]            inv_var;
    logic [AWIDTH-1:0]            address_mat_a;
    logic [AWIDTH-1:0]            address_mat_b;
    logic [AWIDTH-1:0]            address_mat_c;
    logic [ADDR_STRIDE_WIDTH-1:0] address_stride_a;
    logic [ADDR_STRIDE_WIDTH-1:0] address_stride_b;
    logic [ADDR_STRIDE_WIDTH-1:0] address_stride_c;
    logic [MASK_WIDTH-1:0]        validity_mask;
    logic                         save_output_to_accum;
    logic                         add_accum_to_output;

    modport cfg (
        output start, enable_matmul, enable_norm, enable_activation, activation_type,
        output mean, inv_var, address_mat_a, address_mat_b, address_mat_c,
        output address_stride_a, address_stride_b, address_stride_c, validity_mask,
        output save_output_to_accum, add_accum_to_output,
        input  done
    );

    modport engine (
        input  start, enable_matmul, enable_norm, enable_activation, activation_type,
        input  mean, inv_var, address_mat_a, address_mat_b, address_mat_c,
        input  address_stride_a, address_stride_b, address_stride_c, validity_mask,
        input  save_output_to_accum, add_accum_to_output,
        output done
    );
endinterface

`default_nettype wire

// ==== logic/tpu_pkg.sv ====
`default_nettype none

package tpu_pkg;

    // apb bus
    localparam int REG_ADDRWIDTH = 12;
    localparam int REG_DATAWIDTH = 32;

    // datapath and memory sizes
    localparam int DWIDTH            = 16;
    localparam int AWIDTH            = 6;
    localparam int MASK_WIDTH        = 8;
    localparam int ADDR_STRIDE_WIDTH = 6;
    localparam int MAX_BITS_POOL     = 3;
    localparam int NORM_SHIFT        = 8;
    localparam int MAT_MUL_SIZE      = 1;

    // register byte addresses
    localparam logic [REG_ADDRWIDTH-1:0] REG_ENABLES_ADDR         = 12'h000;
    localparam logic [REG_ADDRWIDTH-1:0] REG_STDN_TPU_ADDR        = 12'h004;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MEAN_ADDR            = 12'h008;
    localparam logic [REG_ADDRWIDTH-1:0] REG_INV_VAR_ADDR         = 12'h00C;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_A_ADDR        = 12'h010;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_B_ADDR        = 12'h014;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_C_ADDR        = 12'h018;
    localparam logic [REG_ADDRWIDTH-1:0] REG_VALID_MASK_ADDR      = 12'h01C;
    localparam logic [REG_ADDRWIDTH-1:0] REG_POOL_KERNEL_SIZE     = 12'h020;
    localparam logic [REG_ADDRWIDTH-1:0] REG_ACCUM_ACTIONS_ADDR   = 12'h024;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_A_STRIDE_ADDR = 12'h028;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_B_STRIDE_ADDR = 12'h02C;
    localparam logic [REG_ADDRWIDTH-1:0] REG_MATRIX_C_STRIDE_ADDR = 12'h030;
    localparam logic [REG_ADDRWIDTH-1:0] REG_ACTIVATION_CSR_ADDR  = 12'h034;

    // scratch memory window, word address taken from PADDR[7:2]
    localparam logic [REG_ADDRWIDTH-1:0] MEM_WINDOW_BASE = 12'h100;
    localparam logic [REG_ADDRWIDTH-1:0] MEM_WINDOW_MASK = 12'hF00;

    // activation types
    localparam logic ACT_RELU  = 1'b0;
    localparam logic ACT_CLAMP = 1'b1;

endpackage

`default_nettype wire

// ==== logic/tpu_top.sv ====
`default_nettype none

module tpu_top import tpu_pkg::*; #(
    parameter int AWIDTH     = tpu_pkg::AWIDTH,
    parameter int MASK_WIDTH = tpu_pkg::MASK_WIDTH
) (
    input  logic                     PCLK,
    input  logic                     PRESETn,
    input  logic [REG_ADDRWIDTH-1:0] PADDR,
    input  logic                     PWRITE,
    input  logic                     PSEL,
    input  logic                     PENABLE,
    input  logic [REG_DATAWIDTH-1:0] PWDATA,
    output logic [REG_DATAWIDTH-1:0] PRDATA,
    output logic                     PREADY
);

    // configuration and status between register file and engine
    tpu_cfg_if #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) cfg_bus ();

    // host side and engine side of the scratch memory
    mem_port_if #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) host_port ();
    mem_port_if #(.AWIDTH(AWIDTH), .DWIDTH(DWIDTH)) eng_port ();

    cfg_regs i_cfg_regs (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .PADDR   (PADDR),
        .PWRITE  (PWRITE),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .cfg     (cfg_bus.cfg),
        .mem     (host_port.requester)
    );

    scratch_mem #(
        .AWIDTH (AWIDTH)
    ) i_scratch_mem (
        .PCLK (PCLK),
        .host (host_port.memory),
        .eng  (eng_port.memory)
    );

    vec_engine #(
        .MASK_WIDTH (MASK_WIDTH)
    ) i_vec_engine (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .cfg     (cfg_bus.engine),
        .mem     (eng_port.requester)
    );

endmodule

`default_nettype wire

// ==== logic/vec_engine.sv ====
`default_nettype none

module vec_engine import tpu_pkg::*; #(
    parameter int MASK_WIDTH = tpu_pkg::MASK_WIDTH
) (
    input logic           PCLK,
    input logic           PRESETn,
    tpu_cfg_if.engine     cfg,
    mem_port_if.requester mem
);

    localparam int LW = $clog2(MASK_WIDTH);
    localparam int CW = 32;
    localparam int TW = AWIDTH + ADDR_STRIDE_WIDTH + LW;
    localparam logic signed [CW-1:0] CLAMP_HI = 127;
    localparam logic signed [CW-1:0] CLAMP_LO = -128;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_A,
        ST_RD_B,
        ST_COMPUTE,
        ST_WR_C
    } eng_state_t;

    eng_state_t               state;
    logic [LW-1:0]            lane;
    logic                     last_lane;
    logic signed [DWIDTH-1:0] a_q;
    logic [DWIDTH-1:0]        res_q;
    logic signed [CW-1:0]     accum [MASK_WIDTH];
    logic [AWIDTH-1:0]        a_addr;
    logic [AWIDTH-1:0]        b_addr;
    logic [AWIDTH-1:0]        c_addr;
    logic signed [CW-1:0]     a_val;
    logic signed [CW-1:0]     b_val;
    logic signed [CW-1:0]     mul_val;
    logic signed [CW-1:0]     sum_val;
    logic signed [CW-1:0]     norm_val;
    logic signed [CW-1:0]     act_val;

    // base + lane * stride, wrapping inside the scratch memory
    function automatic logic [AWIDTH-1:0] lane_addr(input logic [AWIDTH-1:0] base,
                                                    input logic [ADDR_STRIDE_WIDTH-1:0] stride,
                                                    input logic [LW-1:0] idx);
        logic [TW-1:0] full;
        full = TW'(base) + TW'(stride) * TW'(idx);
        return full[AWIDTH-1:0];
    endfunction

    assign a_addr    = lane_addr(cfg.address_mat_a, cfg.address_stride_a, lane);
    assign b_addr    = lane_addr(cfg.address_mat_b, cfg.address_stride_b, lane);
    assign c_addr    = lane_addr(cfg.address_mat_c, cfg.address_stride_c, lane);
    assign last_lane = lane == LW'(MASK_WIDTH - 1);

    // skipped lanes issue no read
    assign mem.en    = (state == ST_RD_A && cfg.validity_mask[lane])
                       || state == ST_RD_B || state == ST_WR_C;
    assign mem.we    = state == ST_WR_C;
    assign mem.wdata = res_q;

    always_comb begin
        case (state)
            ST_RD_A: mem.addr = a_addr;
            ST_RD_B: mem.addr = b_addr;
            default: mem.addr = c_addr;
        endcase
    end

    // datapath, valid in ST_COMPUTE when B is on the read port
    always_comb begin
        a_val   = CW'(a_q);
        b_val   = CW'($signed(mem.rdata));
        mul_val = cfg.enable_matmul ? a_val * b_val : a_val;
        sum_val = cfg.add_accum_to_output ? mul_val + accum[lane] : mul_val;
        norm_val = sum_val;
        if (cfg.enable_norm) begin
            norm_val = ((sum_val - CW'($signed(cfg.mean))) * CW'($signed(cfg.inv_var)))
                       >>> NORM_SHIFT;
        end
        act_val = norm_val;
        if (cfg.enable_activation) begin
            case (cfg.activation_type)
                ACT_RELU: begin
                    if (norm_val < 0) act_val = '0;
                end
                ACT_CLAMP: begin
                    if (norm_val > CLAMP_HI) act_val = CLAMP_HI;
                    else if (norm_val < CLAMP_LO) act_val = CLAMP_LO;
                end
            endcase
        end
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state    <= ST_IDLE;
            lane     <= '0;
            cfg.done <= 1'b0;
            for (int i = 0; i < MASK_WIDTH; i++) begin
                accum[i] <= '0;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cfg.start && !cfg.done) begin
                        lane  <= '0;
                        state <= ST_RD_A;
                    end else if (!cfg.start) begin
                        cfg.done <= 1'b0;
                    end
                end
                ST_RD_A: begin
                    if (cfg.validity_mask[lane]) begin
                        state <= ST_RD_B;
                    end else if (last_lane) begin
                        cfg.done <= 1'b1;
                        state    <= ST_IDLE;
                    end else begin
                        lane <= lane + 1'b1;
                    end
                end
                ST_RD_B: state <= ST_COMPUTE;
                ST_COMPUTE: begin
                    if (cfg.save_output_to_accum) begin
                        accum[lane] <= sum_val;
                    end
                    state <= ST_WR_C;
                end
                ST_WR_C: begin
                    if (last_lane) begin
                        cfg.done <= 1'b1;
                        state    <= ST_IDLE;
                    end else begin
                        lane  <= lane + 1'b1;
                        state <= ST_RD_A;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operand and result registers
    always_ff @(posedge PCLK) begin
        if (state == ST_RD_B) begin
            a_q <= $signed(mem.rdata);
        end
        if (state == ST_COMPUTE) begin
            res_q <= act_val[DWIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_tpu_apb.svh ====
`ifndef TB_TPU_APB_SVH
`define TB_TPU_APB_SVH

// one apb transfer, setup then access until PREADY
task automatic apb_transfer(input logic [11:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    @(posedge PCLK);
    #DRIVE_DELAY;
    PADDR   = addr;
    PWRITE  = write;
    PWDATA  = wdata;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    @(posedge PCLK);
    #DRIVE_DELAY;
    PENABLE = 1'b1;
    waits   = 0;
    do begin
        @(posedge PCLK);
        #DRIVE_DELAY;
        waits++;
    end while (!PREADY && waits < READY_LIMIT);
    assert (PREADY) else begin
        $display("PREADY never rose for the transfer at address 0x%03h", addr);
        abort_run();
    end
    rdata   = PRDATA;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_transfer(addr, 1'b1, data, unused);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    apb_transfer(addr, 1'b0, 32'h0, data);
endtask

task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    apb_read(addr, got);
    assert (got == exp) else begin
        $display("error: PRDATA at 0x%03h is 0x%08h, expected 0x%08h", addr, got, exp);
        abort_run();
    end
endtask

function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

task automatic mem_write(input int word, input logic [31:0] data);
    apb_write(MEM_WINDOW_BASE + 12'(word * 4), data);
endtask

task automatic check_mem(input int word, input logic [15:0] exp);
    check_read(MEM_WINDOW_BASE + 12'(word * 4), sext16(exp));
endtask

function automatic int lane_addr(input int base, input int stride, input int lane);
    return (base + stride * lane) % (2 ** AWIDTH);
endfunction

// marker word differs for every scratch address
function automatic logic [15:0] marker_at(input int word);
    return C_MARKER ^ 16'(word);
endfunction

// random A and B per lane, C preset to the marker
task automatic load_operands();
    int c_word;
    for (int l = 0; l < MASK_WIDTH; l++) begin
        a_vals[l] = rand_s8();
        b_vals[l] = rand_s8();
        c_word    = lane_addr(base_c, stride_c, l);
        mem_write(lane_addr(base_a, stride_a, l), 32'(a_vals[l]));
        mem_write(lane_addr(base_b, stride_b, l), 32'(b_vals[l]));
        mem_write(c_word, 32'(marker_at(c_word)));
    end
endtask

// value before normalization, the one the accumulator keeps
function automatic int model_sum(input int a, input int b, input int acc);
    int v;
    v = set_matmul ? a * b : a;
    if (set_add) begin
        v = v + acc;
    end
    return v;
endfunction

function automatic logic [15:0] model_c(input int a, input int b, input int acc);
    int v;
    v = model_sum(a, b, acc);
    if (set_norm) begin
        v = ((v - set_mean) * set_inv_var) >>> NORM_SHIFT;
    end
    if (set_act && set_clamp == ACT_RELU && v < 0) begin
        v = 0;
    end
    if (set_act && set_clamp == ACT_CLAMP) begin
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
    end
    return v[15:0];
endfunction

`endif

// ==== sim/tb_tpu.sv ====
`default_nettype none

module tb_tpu import tpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 3;
    // about 1100 cycles of bus traffic over all tests, the rest is margin
    localparam int MAX_CYCLES   = 4000;
    localparam int READY_LIMIT  = 4;
    localparam int POLL_LIMIT   = 40;
    localparam logic [15:0] C_MARKER = 16'hdead;

    logic                     PCLK;
    logic                     PRESETn;
    logic [REG_ADDRWIDTH-1:0] PADDR;
    logic                     PWRITE;
    logic                     PSEL;
    logic                     PENABLE;
    logic [REG_DATAWIDTH-1:0] PWDATA;
    logic [REG_DATAWIDTH-1:0] PRDATA;
    logic                     PREADY;

    logic [31:0] rng_state;
    int          cycles = 0;

    // operands of the last load and the expected accumulator bank
    int a_vals [MASK_WIDTH];
    int b_vals [MASK_WIDTH];
    int acc_model [MASK_WIDTH];

    // engine settings used by programming, loading and the model
    logic                  set_matmul;
    logic                  set_norm;
    logic                  set_act;
    logic                  set_clamp;
    logic                  set_add;
    logic                  set_save;
    logic [MASK_WIDTH-1:0] set_mask;
    int                    set_mean;
    int                    set_inv_var;
    int                    base_a;
    int                    base_b;
    int                    base_c;
    int                    stride_a;
    int                    stride_b;
    int                    stride_c;

    tpu_top #(
        .AWIDTH     (AWIDTH),
        .MASK_WIDTH (MASK_WIDTH)
    ) i_dut (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .PADDR   (PADDR),
        .PWRITE  (PWRITE),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY)
    );

    initial PCLK = 1'b0;
    always #CLK_HALF PCLK = ~PCLK;

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge PCLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // operands stay in signed 8-bit range so products fit a word
    function automatic int rand_s8();
        logic [31:0] r;
        r = next_rand32();
        return int'($signed(r[7:0]));
    endfunction

    `include "tb_tpu_apb.svh"

    task automatic default_settings();
        set_matmul  = 1'b1;
        set_norm    = 1'b0;
        set_act     = 1'b0;
        set_clamp   = ACT_RELU;
        set_add     = 1'b0;
        set_save    = 1'b0;
        set_mask    = '1;
        set_mean    = 0;
        set_inv_var = 0;
        base_a      = 0;
        base_b      = 16;
        base_c      = 32;
        stride_a    = 1;
        stride_b    = 1;
        stride_c    = 1;
    endtask

    task automatic program_engine();
        apb_write(REG_ENABLES_ADDR, {28'b0, set_act, 1'b0, set_norm, set_matmul});
        apb_write(REG_ACCUM_ACTIONS_ADDR, {30'b0, set_add, set_save});
        apb_write(REG_ACTIVATION_CSR_ADDR, {31'b0, set_clamp});
        apb_write(REG_MEAN_ADDR, 32'(set_mean));
        apb_write(REG_INV_VAR_ADDR, 32'(set_inv_var));
        apb_write(REG_MATRIX_A_ADDR, 32'(base_a));
        apb_write(REG_MATRIX_B_ADDR, 32'(base_b));
        apb_write(REG_MATRIX_C_ADDR, 32'(base_c));
        apb_write(REG_MATRIX_A_STRIDE_ADDR, 32'(stride_a));
        apb_write(REG_MATRIX_B_STRIDE_ADDR, 32'(stride_b));
        apb_write(REG_MATRIX_C_STRIDE_ADDR, 32'(stride_c));
        apb_write(REG_VALID_MASK_ADDR, 32'(set_mask));
    endtask

    // start and poll the status word until done shows up
    task automatic run_engine();
        logic [31:0] status;
        int          polls;
        program_engine();
        apb_write(REG_STDN_TPU_ADDR, 32'h1);
        polls = 0;
        do begin
            apb_read(REG_STDN_TPU_ADDR, status);
            polls++;
        end while (!status[31] && polls < POLL_LIMIT);
        assert (status[31]) else begin
            $display("the engine did not report done after %0d status reads", POLL_LIMIT);
            abort_run();
        end
    endtask

    task automatic stop_engine();
        apb_write(REG_STDN_TPU_ADDR, 32'h0);
        check_read(REG_STDN_TPU_ADDR, 32'h0);
    endtask

    task automatic check_results();
        logic [15:0] exp;
        int          addr;
        for (int l = 0; l < MASK_WIDTH; l++) begin
            addr = lane_addr(base_c, stride_c, l);
            if (set_mask[l]) begin
                exp = model_c(a_vals[l], b_vals[l], acc_model[l]);
            end else begin
                exp = marker_at(addr);
            end
            check_mem(addr, exp);
            if (set_mask[l] && set_save) begin
                acc_model[l] = model_sum(a_vals[l], b_vals[l], acc_model[l]);
            end
        end
    endtask

    task automatic run_and_check();
        load_operands();
        run_engine();
        check_results();
        stop_engine();
    endtask

    task automatic test_reset_values();
        check_read(REG_ENABLES_ADDR, 32'h0);
        check_read(REG_STDN_TPU_ADDR, 32'h0);
        check_read(REG_MEAN_ADDR, 32'h0);
        check_read(REG_INV_VAR_ADDR, 32'h0);
        check_read(REG_MATRIX_A_ADDR, 32'h0);
        check_read(REG_MATRIX_B_ADDR, 32'h0);
        check_read(REG_MATRIX_C_ADDR, 32'h0);
        check_read(REG_VALID_MASK_ADDR, 32'h0000_00ff);
        check_read(REG_POOL_KERNEL_SIZE, 32'h1);
        check_read(REG_ACCUM_ACTIONS_ADDR, 32'h0);
        check_read(REG_MATRIX_A_STRIDE_ADDR, 32'h1);
        check_read(REG_MATRIX_B_STRIDE_ADDR, 32'h1);
        check_read(REG_MATRIX_C_STRIDE_ADDR, 32'h1);
        check_read(REG_ACTIVATION_CSR_ADDR, 32'h0);
        check_read(12'h080, 32'h0);
    endtask

    task automatic check_field(input logic [11:0] addr, input logic [31:0] field);
        logic [31:0] val;
        val = next_rand32();
        apb_write(addr, val);
        check_read(addr, val & field);
    endtask

    task automatic test_register_readback();
        logic [31:0] val;
        check_field(REG_ENABLES_ADDR, 32'h0000_000f);
        check_field(REG_MEAN_ADDR, 32'h0000_ffff);
        check_field(REG_INV_VAR_ADDR, 32'h0000_ffff);
        check_field(REG_MATRIX_A_ADDR, 32'h0000_003f);
        check_field(REG_MATRIX_B_ADDR, 32'h0000_003f);
        check_field(REG_MATRIX_C_ADDR, 32'h0000_003f);
        check_field(REG_VALID_MASK_ADDR, 32'h0000_00ff);
        check_field(REG_POOL_KERNEL_SIZE, 32'h0000_0007);
        check_field(REG_ACCUM_ACTIONS_ADDR, 32'h0000_0003);
        check_field(REG_MATRIX_A_STRIDE_ADDR, 32'h0000_003f);
        check_field(REG_MATRIX_B_STRIDE_ADDR, 32'h0000_003f);
        check_field(REG_MATRIX_C_STRIDE_ADDR, 32'h0000_003f);
        check_field(REG_ACTIVATION_CSR_ADDR, 32'h0000_0001);
        // all unmapped addresses share one register
        val = next_rand32();
        apb_write(12'h080, val);
        check_read(12'h084, val);
        check_read(12'h0fc, val);
        check_read(12'h200, val);
    endtask

    task automatic test_memory_window();
        logic [31:0] vals [8];
        for (int i = 0; i < 8; i++) begin
            vals[i] = next_rand32();
            mem_write((i * 9) % 64, vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            check_mem((i * 9) % 64, vals[i][15:0]);
        end
    endtask

    task automatic test_masked_multiply();
        default_settings();
        base_b   = 8;
        stride_b = 2;
        set_mask = 8'b1011_0101;
        run_and_check();
    endtask

    task automatic test_accum_norm_act();
        default_settings();
        set_save = 1'b1;
        run_and_check();
        set_save    = 1'b0;
        set_add     = 1'b1;
        set_norm    = 1'b1;
        set_act     = 1'b1;
        set_mean    = rand_s8();
        set_inv_var = rand_s8();
        run_and_check();
        set_clamp   = ACT_CLAMP;
        set_mean    = rand_s8();
        set_inv_var = rand_s8();
        run_and_check();
    endtask

    task automatic test_start_done();
        default_settings();
        load_operands();
        run_engine();
        check_read(REG_STDN_TPU_ADDR, 32'h8000_0001);
        // new A words would change C if the engine ran again
        for (int l = 0; l < MASK_WIDTH; l++) begin
            mem_write(lane_addr(base_a, stride_a, l), 32'(a_vals[l] + 5));
        end
        check_read(REG_STDN_TPU_ADDR, 32'h8000_0001);
        check_results();
        stop_engine();
    endtask

    initial begin
        PRESETn   = 1'b0;
        PADDR     = '0;
        PWRITE    = 1'b0;
        PSEL      = 1'b0;
        PENABLE   = 1'b0;
        PWDATA    = '0;
        rng_state = 32'hc8a0_38f4;
        for (int l = 0; l < MASK_WIDTH; l++) begin
            acc_model[l] = 0;
        end
        default_settings();
        repeat (RESET_CYCLES) @(posedge PCLK);
        #DRIVE_DELAY;
        PRESETn = 1'b1;

        test_reset_values();
        test_register_readback();
        test_memory_window();
        test_masked_multiply();
        test_accum_norm_act();
        test_start_done();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
logic/tpu_pkg.sv
logic/tpu_cfg_if.sv
logic/mem_port_if.sv
logic/cfg_regs.sv
logic/scratch_mem.sv
logic/vec_engine.sv
logic/tpu_top.sv
sim/tb_tpu.sv
